/* bench/tb_clkgen.sv */
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 5
) (
  output logic o_clk,
  output logic o_rst
);

  // Free running clock, first rising edge at half a period
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Release lands just after an edge, like all other stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

/* bench/tb_rr_top.sv */
`timescale 1ns/1ns

module tb_rr_top import rr_pkg::*; ();

  localparam int DATA_W        = 16;
  localparam int MODE_STAGES   = 4;
  localparam int LOG_DEPTH     = 8;
  localparam int TRACE_CREDITS = 4;
  localparam int RP_DEPTH      = 4;
  localparam int WORD_W        = CHAN_W + DATA_W;

  // Words per channel, passthrough then record
  localparam int N_PASS    = 20;
  localparam int N_REC     = 24;
  localparam int OFFER_MAX = N_PASS + N_REC;
  // Shell words of two phases plus the recorded trace replayed once and then twice
  localparam int TOTAL_TXN      = NUM_CHAN * (N_PASS + N_REC) + 3 * NUM_CHAN * N_REC;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_TXN + 200;
  localparam logic [31:0] SEED  = 32'h41b215ca;

  logic                            clk;
  logic                            rst;
  logic                            i_cfg_we;
  logic [MODE_W-1:0]               i_cfg_data;
  logic [NUM_CHAN-1:0]             i_sh_valid;
  logic [NUM_CHAN-1:0][DATA_W-1:0] i_sh_data;
  logic [NUM_CHAN-1:0]             o_sh_ready;
  logic [NUM_CHAN-1:0]             o_cl_valid;
  logic [NUM_CHAN-1:0][DATA_W-1:0] o_cl_data;
  logic [NUM_CHAN-1:0]             i_cl_ready;
  logic                            o_trace_valid;
  logic [WORD_W-1:0]               o_trace_word;
  logic                            i_trace_credit;
  logic                            i_rp_valid;
  logic [WORD_W-1:0]               i_rp_word;
  logic                            o_rp_credit;

  //////////////////////////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////////////////////////

  // Shell words offered per channel, in order
  logic [DATA_W-1:0] offer_mem [NUM_CHAN][OFFER_MAX];
  int                offer_wr [NUM_CHAN];
  int                offer_rd [NUM_CHAN];
  int                sent [NUM_CHAN];
  logic [WORD_W-1:0] exp_trace_q [$];
  // Trace captured while recording, fed back in the replay phases
  logic [WORD_W-1:0] rec_trace [$];
  logic [NUM_CHAN-1:0] sh_xfer = '0;
  bit  idle        = 1'b1;
  bit  mdl_rec     = 1'b0;
  bit  mdl_rp      = 1'b0;
  bit  keep_trace  = 1'b0;
  bit  rp_pop_prev = 1'b0;
  int  sh_target   = 0;
  int  rp_target   = 0;
  int  rp_sent     = 0;
  int  rp_chk      = 0;
  int  rp_returned = 0;
  int  trace_owed  = 0;
  int  err_cnt     = 0;
  int  hs_cnt      = 0;
  int  trace_cnt   = 0;
  int  cycle_cnt   = 0;

  tb_clkgen #(.PERIOD(10), .RST_CYCLES(5)) i_clkgen (.o_clk(clk), .o_rst(rst));

  rr_top #(
    .DATA_W        (DATA_W),
    .MODE_STAGES   (MODE_STAGES),
    .LOG_DEPTH     (LOG_DEPTH),
    .TRACE_CREDITS (TRACE_CREDITS),
    .RP_DEPTH      (RP_DEPTH)
  ) i_rr_top (
    .clk            (clk),
    .i_rst          (rst),
    .i_cfg_we       (i_cfg_we),
    .i_cfg_data     (i_cfg_data),
    .i_sh_valid     (i_sh_valid),
    .i_sh_data      (i_sh_data),
    .o_sh_ready     (o_sh_ready),
    .o_cl_valid     (o_cl_valid),
    .o_cl_data      (o_cl_data),
    .i_cl_ready     (i_cl_ready),
    .o_trace_valid  (o_trace_valid),
    .o_trace_word   (o_trace_word),
    .i_trace_credit (i_trace_credit),
    .i_rp_valid     (i_rp_valid),
    .i_rp_word      (i_rp_word),
    .o_rp_credit    (o_rp_credit)
  );

  task automatic log_error(input string msg);
    err_cnt++;
    $display("ERROR @%0t: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor sampling mid-cycle where every signal is settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    logic [NUM_CHAN-1:0] cl_hs;
    logic [NUM_CHAN-1:0] sh_hs;
    logic [WORD_W-1:0]   exp_word;
    cl_hs   = o_cl_valid & i_cl_ready;
    sh_hs   = i_sh_valid & o_sh_ready;
    sh_xfer = sh_hs;
    if (idle) begin
      if (o_trace_valid !== 1'b0 || o_rp_credit !== 1'b0 || o_sh_ready !== '0 ||
          o_cl_valid !== '0)
        log_error("outputs not low after reset");
    end else begin
      // Trace output against the credit count and expected order
      if (o_trace_valid) begin
        if (trace_owed >= TRACE_CREDITS) log_error("trace word sent with no credit left");
        if (exp_trace_q.size() == 0) begin
          log_error($sformatf("unexpected trace word %h", o_trace_word));
        end else begin
          exp_word = exp_trace_q.pop_front();
          if (o_trace_word !== exp_word)
            log_error($sformatf("trace word %h, expected %h", o_trace_word, exp_word));
          if (keep_trace) rec_trace.push_back(exp_word);
        end
        trace_owed++;
        trace_cnt++;
      end
      if (i_trace_credit) trace_owed--;
      // Shell is cut off in replay, otherwise it moves with the CL
      if (mdl_rp && o_sh_ready !== '0) log_error("o_sh_ready high in replay mode");
      if (!mdl_rp && sh_hs !== cl_hs)
        log_error($sformatf("shell transfers %b, CL handshakes %b", sh_hs, cl_hs));
      if (mdl_rec && $countones(cl_hs) > 1)
        log_error($sformatf("handshakes %b on several channels while recording", cl_hs));
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (cl_hs[c]) begin
          if (mdl_rp && rp_chk >= rp_target) begin
            log_error("CL handshake beyond the replayed trace");
          end else if (!mdl_rp && offer_rd[c] >= offer_wr[c]) begin
            log_error($sformatf("CL handshake on channel %0d with no shell word", c));
          end else begin
            if (mdl_rp) begin
              exp_word = rec_trace[rp_chk % rec_trace.size()];
              rp_chk++;
            end else begin
              exp_word = {CHAN_W'(c), offer_mem[c][offer_rd[c]]};
              offer_rd[c]++;
            end
            // Tag names the channel, payload is the CL data
            if ({CHAN_W'(c), o_cl_data[c]} !== exp_word)
              log_error($sformatf("channel %0d CL data %h, expected word %h",
                                  c, o_cl_data[c], exp_word));
            if (mdl_rec) exp_trace_q.push_back(exp_word);
          end
          hs_cnt++;
        end
      end
      // One credit pulse, one cycle after each replay pop
      if (o_rp_credit !== rp_pop_prev)
        log_error($sformatf("o_rp_credit %b, expected %b", o_rp_credit, rp_pop_prev));
      if (o_rp_credit) rp_returned++;
      if (rp_returned > rp_sent) log_error("more replay credits returned than words sent");
      rp_pop_prev = mdl_rp && (cl_hs != '0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input bit traffic);
    logic [DATA_W-1:0] word;
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (traffic && mdl_rp) begin
        // Random shell noise, never to reach the CL
        i_sh_valid[c] = 1'($urandom % 2);
        i_sh_data[c]  = DATA_W'($urandom);
      end else if (i_sh_valid[c] && !sh_xfer[c]) begin
        // Offered word held until taken
      end else if (traffic && sent[c] < sh_target && ($urandom % 3) != 0) begin
        word = DATA_W'($urandom);
        i_sh_valid[c] = 1'b1;
        i_sh_data[c]  = word;
        offer_mem[c][offer_wr[c]] = word;
        offer_wr[c]++;
        sent[c]++;
      end else begin
        i_sh_valid[c] = 1'b0;
      end
      i_cl_ready[c] = ($urandom % 4) != 0;
    end
    // Credits come back late and at random
    i_trace_credit = (trace_owed > 0) && (($urandom % 2) == 0);
    if (traffic && mdl_rp && rp_sent < rp_target && (rp_sent - rp_returned) < RP_DEPTH &&
        ($urandom % 2) == 0) begin
      i_rp_valid = 1'b1;
      i_rp_word  = rec_trace[rp_sent % rec_trace.size()];
      rp_sent++;
    end else begin
      i_rp_valid = 1'b0;
    end
  endtask

  function automatic bit phase_done();
    bit done;
    done = (exp_trace_q.size() == 0) && (rp_chk == rp_target) && (rp_sent == rp_returned);
    for (int c = 0; c < NUM_CHAN; c++) begin
      done = done && (sent[c] == sh_target) && (offer_rd[c] == offer_wr[c]);
    end
    return done;
  endfunction

  // Mode write, quiet settling, then traffic until the model is drained
  task automatic run_phase(input bit rec, input bit rp, input int sh_goal, input int rp_goal,
                           input bit keep);
    idle = 1'b0;
    @(posedge clk);
    #1;
    i_cfg_we   = 1'b1;
    i_cfg_data = '0;
    i_cfg_data[MODE_REC_BIT] = rec;
    i_cfg_data[MODE_RP_BIT]  = rp;
    drive_cycle(1'b0);
    repeat (MODE_STAGES + 2) begin
      @(posedge clk);
      #1;
      i_cfg_we = 1'b0;
      drive_cycle(1'b0);
    end
    mdl_rec    = rec;
    mdl_rp     = rp;
    keep_trace = keep;
    sh_target  = sh_goal;
    rp_target  = rp_goal;
    do begin
      @(posedge clk);
      #1;
      drive_cycle(1'b1);
    end while (!phase_done());
    i_sh_valid = '0;
    keep_trace = 1'b0;
  endtask

  initial begin : main
    i_cfg_we       = 1'b0;
    i_cfg_data     = '0;
    i_sh_valid     = '0;
    i_sh_data      = '0;
    i_cl_ready     = '0;
    i_trace_credit = 1'b0;
    i_rp_valid     = 1'b0;
    i_rp_word      = '0;
    for (int c = 0; c < NUM_CHAN; c++) begin
      offer_wr[c] = 0;
      offer_rd[c] = 0;
      sent[c]     = 0;
    end
    void'($urandom(SEED));
    wait (rst == 1'b0);
    repeat (4) @(posedge clk);
    // Passthrough, then record, then replay, then both
    run_phase(1'b0, 1'b0, N_PASS, 0, 1'b0);
    run_phase(1'b1, 1'b0, N_PASS + N_REC, 0, 1'b1);
    if (rec_trace.size() != NUM_CHAN * N_REC)
      log_error($sformatf("recorded %0d trace words, expected %0d",
                          rec_trace.size(), NUM_CHAN * N_REC));
    run_phase(1'b0, 1'b1, N_PASS + N_REC, rec_trace.size(), 1'b0);
    run_phase(1'b1, 1'b1, N_PASS + N_REC, 2 * rec_trace.size(), 1'b0);
    repeat (4) begin
      @(posedge clk);
      #1;
      drive_cycle(1'b0);
    end
    $display("Summary: %0d errors, %0d CL handshakes, %0d trace words, %0d cycles",
             err_cnt, hs_cnt, trace_cnt, cycle_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Run limit scaled to the transaction count
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

endmodule

/* hw/rr_mode_ctrl.sv */
`timescale 1ns/1ns

module rr_mode_ctrl import rr_pkg::*; #(
  parameter int DATA_W      = 16,
  parameter int MODE_STAGES = 4
) (
  input  logic                            clk,
  input  logic                            i_rst,
  input  logic                            i_cfg_we,
  input  logic [MODE_W-1:0]               i_cfg_data,
  input  logic [NUM_CHAN-1:0]             i_sh_valid,
  input  logic [NUM_CHAN-1:0][DATA_W-1:0] i_sh_data,
  output logic [NUM_CHAN-1:0]             o_sh_ready,
  output logic [NUM_CHAN-1:0]             o_cl_valid,
  output logic [NUM_CHAN-1:0][DATA_W-1:0] o_cl_data,
  input  logic [NUM_CHAN-1:0]             i_cl_ready,
  input  logic                            i_log_full,
  output logic                            o_log_push,
  output logic [CHAN_W+DATA_W-1:0]        o_log_word,
  output logic                            o_rec_en,
  output logic                            o_replay_en,
  input  logic                            i_rp_valid,
  input  logic [CHAN_W-1:0]               i_rp_chan,
  input  logic [DATA_W-1:0]               i_rp_data,
  output logic                            o_rp_pop
);

  //////////////////////////////////////////////////////////////////////
  // Mode register and staging pipe
  //////////////////////////////////////////////////////////////////////

  // Stage 0 is the mode register itself, the last stage feeds the datapath
  logic [MODE_W-1:0] mode_pipe [MODE_STAGES];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int s = 0; s < MODE_STAGES; s++) begin
        mode_pipe[s] <= '0;
      end
    end else begin
      if (i_cfg_we) begin
        mode_pipe[0] <= i_cfg_data;
      end
      // Shift so the mode reaches all channels in the same cycle
      for (int s = 1; s < MODE_STAGES; s++) begin
        mode_pipe[s] <= mode_pipe[s-1];
      end
    end
  end

  assign o_rec_en    = mode_pipe[MODE_STAGES-1][MODE_REC_BIT];
  assign o_replay_en = mode_pipe[MODE_STAGES-1][MODE_RP_BIT];

  //////////////////////////////////////////////////////////////////////
  // Round-robin record grant
  //////////////////////////////////////////////////////////////////////

  // Channel with top priority this cycle
  logic [CHAN_W-1:0]   rr_ptr;
  logic [NUM_CHAN-1:0] grant;
  logic                grant_any;
  logic [CHAN_W-1:0]   grant_idx;
  // Completed CL handshakes, one bit per channel
  logic [NUM_CHAN-1:0] hs;

  // First valid shell channel at or after rr_ptr wins
  always_comb begin
    int idx;
    grant     = '0;
    grant_any = 1'b0;
    grant_idx = '0;
    for (int i = 0; i < NUM_CHAN; i++) begin
      idx = (int'(rr_ptr) + i) % NUM_CHAN;
      if (!grant_any && i_sh_valid[idx]) begin
        grant[idx] = 1'b1;
        grant_any  = 1'b1;
        grant_idx  = CHAN_W'(idx);
      end
    end
  end

  // Move past the winner once it handshakes, else park on it
  // so an offered word stays offered to the CL until accepted
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rr_ptr <= '0;
    end else if (o_rec_en && !o_replay_en && grant_any) begin
      if (hs[grant_idx]) begin
        rr_ptr <= (grant_idx == CHAN_W'(NUM_CHAN - 1)) ? '0 : grant_idx + 1'b1;
      end else begin
        rr_ptr <= grant_idx;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Source select toward the CL
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (o_replay_en) begin
        // Shell is cut off, only the tagged channel sees the trace head
        o_cl_valid[c] = i_rp_valid && (i_rp_chan == CHAN_W'(c)) && !(o_rec_en && i_log_full);
        o_cl_data[c]  = i_rp_data;
        o_sh_ready[c] = 1'b0;
      end else if (o_rec_en) begin
        // One granted channel at a time, all paused while the log is full
        o_cl_valid[c] = grant[c] && !i_log_full;
        o_cl_data[c]  = i_sh_data[c];
        o_sh_ready[c] = grant[c] && i_cl_ready[c] && !i_log_full;
      end else begin
        o_cl_valid[c] = i_sh_valid[c];
        o_cl_data[c]  = i_sh_data[c];
        o_sh_ready[c] = i_cl_ready[c];
      end
    end
  end

  assign hs = o_cl_valid & i_cl_ready;

  // Trace word of this cycle's handshake, tag above payload
  always_comb begin
    o_log_word = '0;
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (hs[c]) begin
        o_log_word = {CHAN_W'(c), o_cl_data[c]};
      end
    end
  end

  assign o_log_push = o_rec_en && (|hs);
  // In replay only the head's channel can handshake
  assign o_rp_pop   = o_replay_en && (|hs);

  // Single total order in the trace, whatever the CL does with ready
  a_one_hs_rec: assert property (@(posedge clk) disable iff (i_rst)
    o_rec_en |-> $onehot0(hs));

endmodule

/* hw/rr_pkg.sv */
package rr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Channel geometry
  //////////////////////////////////////////////////////////////////////

  // Inbound valid/ready channels between shell and CL
  localparam int NUM_CHAN = 2;

  // Channel tag carried above the payload in each trace word
  localparam int CHAN_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

  //////////////////////////////////////////////////////////////////////
  // Mode configuration word
  //////////////////////////////////////////////////////////////////////

  // Two bits, record enable and replay enable
  localparam int MODE_W = 2;

  // Record every CL handshake into the trace
  localparam int MODE_REC_BIT = 0;

  // Disconnect the shell and drive the CL from the trace input
  localparam int MODE_RP_BIT = 1;

endpackage

/* hw/rr_replay_decoder.sv */
`timescale 1ns/1ns

module rr_replay_decoder import rr_pkg::*; #(
  parameter int DATA_W   = 16,
  parameter int RP_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     i_rst,
  input  logic                     i_replay_en,
  input  logic                     i_rp_valid,
  input  logic [CHAN_W+DATA_W-1:0] i_rp_word,
  input  logic                     i_pop,
  output logic                     o_valid,
  output logic [CHAN_W-1:0]        o_chan,
  output logic [DATA_W-1:0]        o_data,
  output logic                     o_rp_credit
);

  localparam int WORD_W = CHAN_W + DATA_W;
  localparam int AW     = (RP_DEPTH > 1) ? $clog2(RP_DEPTH) : 1;

  //////////////////////////////////////////////////////////////////////
  // Replay buffer
  //////////////////////////////////////////////////////////////////////

  // One slot per sender credit
  logic [WORD_W-1:0] mem [RP_DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;
  logic              full;
  logic              wr_en;
  logic              rd_en;
  logic [WORD_W-1:0] head;

  assign full  = (count == (AW + 1)'(RP_DEPTH));
  assign wr_en = i_rp_valid && !full;
  assign rd_en = i_pop && o_valid;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_rp_word;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(RP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(RP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (!wr_en && rd_en) begin
        count <= count - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Head decode and credit return
  //////////////////////////////////////////////////////////////////////

  // Words may be preloaded, but only offered once replay is on
  assign head    = mem[rd_ptr];
  assign o_valid = i_replay_en && (count != '0);
  assign o_chan  = head[WORD_W-1:DATA_W];
  assign o_data  = head[DATA_W-1:0];

  // Credit leaves the cycle after the CL takes the word
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_rp_credit <= 1'b0;
    end else begin
      o_rp_credit <= rd_en;
    end
  end

  // Sender stays within RP_DEPTH credits
  a_no_overrun: assert property (@(posedge clk) disable iff (i_rst)
    i_rp_valid |-> !full);

endmodule

/* hw/rr_top.sv */
`timescale 1ns/1ns

module rr_top import rr_pkg::*; #(
  parameter int DATA_W        = 16,
  parameter int MODE_STAGES   = 4,
  parameter int LOG_DEPTH     = 8,
  parameter int TRACE_CREDITS = 4,
  parameter int RP_DEPTH      = 4
) (
  input  logic                            clk,
  input  logic                            i_rst,
  // Mode configuration
  input  logic                            i_cfg_we,
  input  logic [MODE_W-1:0]               i_cfg_data,
  // Shell side
  input  logic [NUM_CHAN-1:0]             i_sh_valid,
  input  logic [NUM_CHAN-1:0][DATA_W-1:0] i_sh_data,
  output logic [NUM_CHAN-1:0]             o_sh_ready,
  // CL side
  output logic [NUM_CHAN-1:0]             o_cl_valid,
  output logic [NUM_CHAN-1:0][DATA_W-1:0] o_cl_data,
  input  logic [NUM_CHAN-1:0]             i_cl_ready,
  // Credited trace output
  output logic                            o_trace_valid,
  output logic [CHAN_W+DATA_W-1:0]        o_trace_word,
  input  logic                            i_trace_credit,
  // Credited trace input
  input  logic                            i_rp_valid,
  input  logic [CHAN_W+DATA_W-1:0]        i_rp_word,
  output logic                            o_rp_credit
);

  //////////////////////////////////////////////////////////////////////
  // Control to datapath wiring
  //////////////////////////////////////////////////////////////////////

  logic                     log_push;
  logic [CHAN_W+DATA_W-1:0] log_word;
  logic                     log_full;
  logic                     rec_en;
  logic                     replay_en;
  logic                     rp_valid;
  logic [CHAN_W-1:0]        rp_chan;
  logic [DATA_W-1:0]        rp_data;
  logic                     rp_pop;

  rr_mode_ctrl #(
    .DATA_W      (DATA_W),
    .MODE_STAGES (MODE_STAGES)
  ) i_mode_ctrl (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_data  (i_cfg_data),
    .i_sh_valid  (i_sh_valid),
    .i_sh_data   (i_sh_data),
    .o_sh_ready  (o_sh_ready),
    .o_cl_valid  (o_cl_valid),
    .o_cl_data   (o_cl_data),
    .i_cl_ready  (i_cl_ready),
    .i_log_full  (log_full),
    .o_log_push  (log_push),
    .o_log_word  (log_word),
    .o_rec_en    (rec_en),
    .o_replay_en (replay_en),
    .i_rp_valid  (rp_valid),
    .i_rp_chan   (rp_chan),
    .i_rp_data   (rp_data),
    .o_rp_pop    (rp_pop)
  );

  // Record side
  rr_trace_log #(
    .DATA_W        (DATA_W),
    .LOG_DEPTH     (LOG_DEPTH),
    .TRACE_CREDITS (TRACE_CREDITS)
  ) i_trace_log (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_rec_en       (rec_en),
    .i_push         (log_push),
    .i_word         (log_word),
    .i_trace_credit (i_trace_credit),
    .o_full         (log_full),
    .o_trace_valid  (o_trace_valid),
    .o_trace_word   (o_trace_word)
  );

  // Replay side
  rr_replay_decoder #(
    .DATA_W   (DATA_W),
    .RP_DEPTH (RP_DEPTH)
  ) i_replay_decoder (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_replay_en (replay_en),
    .i_rp_valid  (i_rp_valid),
    .i_rp_word   (i_rp_word),
    .i_pop       (rp_pop),
    .o_valid     (rp_valid),
    .o_chan      (rp_chan),
    .o_data      (rp_data),
    .o_rp_credit (o_rp_credit)
  );

endmodule

/* hw/rr_trace_log.sv */
`timescale 1ns/1ns

module rr_trace_log import rr_pkg::*; #(
  parameter int DATA_W        = 16,
  parameter int LOG_DEPTH     = 8,
  parameter int TRACE_CREDITS = 4
) (
  input  logic                     clk,
  input  logic                     i_rst,
  input  logic                     i_rec_en,
  input  logic                     i_push,
  input  logic [CHAN_W+DATA_W-1:0] i_word,
  input  logic                     i_trace_credit,
  output logic                     o_full,
  output logic                     o_trace_valid,
  output logic [CHAN_W+DATA_W-1:0] o_trace_word
);

  localparam int WORD_W = CHAN_W + DATA_W;
  localparam int AW     = (LOG_DEPTH > 1) ? $clog2(LOG_DEPTH) : 1;
  localparam int CW     = $clog2(TRACE_CREDITS + 1);

  //////////////////////////////////////////////////////////////////////
  // Trace FIFO
  //////////////////////////////////////////////////////////////////////

  logic [WORD_W-1:0] mem [LOG_DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;
  logic              wr_en;
  logic              rd_en;
  // Words the receiver can still take
  logic [CW-1:0]     credits;

  assign o_full = (count == (AW + 1)'(LOG_DEPTH));
  assign wr_en  = i_push && i_rec_en && !o_full;

  // Send needs a stored word and a credit, no skid on the far side
  assign o_trace_valid = (count != '0) && (credits != '0);
  assign rd_en         = o_trace_valid;
  assign o_trace_word  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_word;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(LOG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      // Drain goes on after record is dropped
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(LOG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (!wr_en && rd_en) begin
        count <= count - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Trace output credits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      credits <= CW'(TRACE_CREDITS);
    end else if (rd_en && !i_trace_credit) begin
      credits <= credits - 1'b1;
    end else if (!rd_en && i_trace_credit) begin
      credits <= credits + 1'b1;
    end
  end

  // Control must hold off the CL while the log is full
  a_no_push_full: assert property (@(posedge clk) disable iff (i_rst)
    i_push |-> !o_full);

  // Receiver never returns more than it was sent
  a_credit_bound: assert property (@(posedge clk) disable iff (i_rst)
    (credits == CW'(TRACE_CREDITS) && !rd_en) |-> !i_trace_credit);

endmodule

/* project.f */
hw/rr_pkg.sv
hw/rr_mode_ctrl.sv
hw/rr_trace_log.sv
hw/rr_replay_decoder.sv
hw/rr_top.sv
bench/tb_clkgen.sv
bench/tb_rr_top.sv
